// File: fetch_checker.sv
`timescale 1ns/100ps

module fetch_checker (
    input  logic                         clock,
    input  logic                         reset_n,
    input  int                           test_num,     // Running test, 0 between tests
    input  logic                         redirect,
    input  fetch_types_pkg::pc_t         redirect_pc,
    input  logic                         stall,
    input  logic                         imem_req,
    input  fetch_types_pkg::ibuf_entry_t data_out,
    input  logic                         data_valid,
    input  logic                         empty,
    input  logic                         full,
    input  fetch_types_pkg::ibuf_count_t count,
    output int                           error_count,
    output int                           entry_count   // Fresh entries seen so far
);

    import fetch_types_pkg::*;
    import fetch_config_pkg::*;

    pc_t         exp_pc;            // PC of the next fresh entry
    ibuf_entry_t held_out;          // Output seen at the last edge
    logic        held_valid;
    logic        stall_q = 1'b0;    // Stall applied at the last edge
    logic        redirect_q = 1'b0; // Clear applied at the last edge
    logic        out_of_reset = 1'b0;
    int          cur_test = 0;
    int          errors = 0;
    int          entries = 0;
    int          test_errors = 0;
    int          test_entries = 0;

    function automatic string test_label(input int num);
        case (num)
            1:       return "reset_and_first_words";
            2:       return "in_order_stream";
            3:       return "stall_pulses";
            4:       return "redirect_queued";
            5:       return "redirect_outstanding";
            6:       return "back_pressure_drain";
            default: return "idle";
        endcase
    endfunction

    // Memory contents: low address word XOR pattern, rotated left by addr[5:2]
    function automatic instr_t ref_word(input pc_t pc);
        instr_t word;
        word = pc[31:0] ^ 32'h5a5a_0000;
        for (int i = 0; i < pc[5:2]; i++) begin
            word = {word[30:0], word[31]};  // One bit per step
        end
        return word;
    endfunction

    task automatic report_mismatch(input string field, input logic [47:0] expected,
                                   input logic [47:0] actual);
        $display("mismatch %s %s: expected %h, actual %h",
                 test_label(cur_test), field, expected, actual);
        errors++;
        test_errors++;
    endtask

    task automatic report_failure(input string what);
        $display("error in %s: %s", test_label(cur_test), what);
        errors++;
        test_errors++;
    endtask

    always @(posedge clock) begin
        // Close out the previous test
        if (test_num != cur_test) begin
            if (cur_test != 0) begin
                $display("test %0d %s: %0d entries, %0d errors",
                         cur_test, test_label(cur_test), test_entries, test_errors);
            end
            cur_test     = test_num;
            test_entries = 0;
            test_errors  = 0;
        end
        if (!reset_n) begin
            exp_pc       = PC_RESET;
            stall_q      = 1'b0;
            redirect_q   = 1'b0;
            out_of_reset = 1'b0;
        end else begin
            if (!out_of_reset && (imem_req !== 1'b0 || data_valid !== 1'b0
                                  || count !== '0 || empty !== 1'b1)) begin
                report_failure("outputs not at their reset values after reset");
            end
            if (redirect_q && (count !== '0 || data_valid !== 1'b0 || data_out !== '0)) begin
                report_failure("buffer not cleared by the redirect");
            end
            if (full !== 1'b0) report_failure("full flag raised");
            if (count > 6'd61) report_failure("count above 61");
            if (stall_q && !redirect_q) begin
                // Held output, already compared
                if (data_out !== held_out || data_valid !== held_valid) begin
                    report_failure("output changed during stall");
                end
            end else if (data_valid) begin
                if (data_out[79:32] !== exp_pc) begin  // PC half
                    report_mismatch("pc", exp_pc, data_out[79:32]);
                end else if (data_out[31:0] !== ref_word(exp_pc)) begin
                    report_mismatch("instruction", ref_word(exp_pc), data_out[31:0]);
                end
                entries++;
                test_entries++;
                exp_pc = exp_pc + 48'd4;
            end
            if (redirect) exp_pc = redirect_pc;  // After this cycle's compare
            held_out     = data_out;
            held_valid   = data_valid;
            stall_q      = stall;
            redirect_q   = redirect;
            out_of_reset = 1'b1;
        end
        error_count <= errors;
        entry_count <= entries;
    end

endmodule

// File: fetch_config_pkg.sv
package fetch_config_pkg;

    // Buffer geometry
    localparam int unsigned IBUF_DEPTH = 64;  // Storage slots
    localparam int unsigned IBUF_PTR_W = 6;   // Pointer width, wraps at depth

    // Occupancy thresholds, same width as the count
    localparam logic [5:0] IBUF_FULL_COUNT = 6'd63;  // Full flag, last slot never used
    localparam logic [5:0] IBUF_HIGH_WATER = 6'd60;  // No new request at or above

    // The one outstanding request can add a single entry past the high-water
    // mark, so the count tops out well below full

    // Program counter
    localparam logic [47:0] PC_RESET = 48'h0000_0000_1000;  // First fetch address
    localparam logic [47:0] PC_STEP  = 48'd4;               // Bytes per word

endpackage

// File: fetch_frontend.sv
`timescale 1ns/100ps

module fetch_frontend (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         redirect,     // Back end restart pulse
    input  fetch_types_pkg::pc_t         redirect_pc,
    input  logic                         stall,        // Decode stall level
    input  logic                         read_en,      // Decode read level
    input  logic                         imem_rvalid,
    input  fetch_types_pkg::instr_t      imem_rdata,
    output logic                         imem_req,
    output fetch_types_pkg::pc_t         imem_addr,
    output fetch_types_pkg::ibuf_entry_t data_out,
    output logic                         data_valid,
    output logic                         empty,
    output logic                         full,
    output fetch_types_pkg::ibuf_count_t count
);

    import fetch_types_pkg::*;

    pc_t         fetch_pc;     // Address of the open request
    ibuf_entry_t fetch_entry;  // Response paired with its PC
    logic        pc_advance;   // Accepted response, write and step

    assign imem_addr   = fetch_pc;
    assign fetch_entry = {fetch_pc, imem_rdata};  // PC on top

    fetch_pc_counter u_pc_counter (
        .clock       (clock),
        .reset_n     (reset_n),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .pc_advance  (pc_advance),
        .fetch_pc    (fetch_pc)
    );

    // Sequencer watches the count for back-pressure
    fetch_sequencer_fsm u_sequencer (
        .clock       (clock),
        .reset_n     (reset_n),
        .redirect    (redirect),
        .count       (count),
        .imem_rvalid (imem_rvalid),
        .imem_req    (imem_req),
        .pc_advance  (pc_advance)
    );

    instr_buffer u_ibuf (
        .clock         (clock),
        .reset_n       (reset_n),
        .data_in       (fetch_entry),
        .write_en      (pc_advance),
        .read_en       (read_en),
        .clear_ibuffer (redirect),  // Flush in the redirect cycle
        .stall         (stall),
        .data_out      (data_out),
        .empty         (empty),
        .full          (full),
        .count         (count),
        .data_valid    (data_valid)
    );

endmodule

// File: fetch_pc_counter.sv
`timescale 1ns/100ps

module fetch_pc_counter (
    input  logic                 clock,
    input  logic                 reset_n,
    input  logic                 redirect,     // Restart strobe from the back end
    input  fetch_types_pkg::pc_t redirect_pc,  // Restart target
    input  logic                 pc_advance,   // Word accepted into the buffer
    output fetch_types_pkg::pc_t fetch_pc      // Address of the word in flight
);

    import fetch_types_pkg::*;
    import fetch_config_pkg::*;

    pc_t pc_seq;   // Next sequential address
    pc_t pc_next;  // Value taken at the next edge

    assign pc_seq = fetch_pc + PC_STEP;

    // Redirect wins over advance
    always_comb begin
        if (redirect) begin
            pc_next = redirect_pc;  // New stream
        end else if (pc_advance) begin
            pc_next = pc_seq;
        end else begin
            pc_next = fetch_pc;  // Hold while the request is open
        end
    end

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            fetch_pc <= PC_RESET;
        end else begin
            fetch_pc <= pc_next;
        end
    end

endmodule

// File: fetch_sequencer_fsm.sv
`timescale 1ns/100ps

module fetch_sequencer_fsm (
    input  logic                         clock,
    input  logic                         reset_n,
    input  logic                         redirect,     // Back end restart strobe
    input  fetch_types_pkg::ibuf_count_t count,        // Buffer occupancy
    input  logic                         imem_rvalid,  // Memory response strobe
    output logic                         imem_req,     // One-cycle request strobe
    output logic                         pc_advance    // Response goes into the buffer
);

    import fetch_types_pkg::*;
    import fetch_config_pkg::*;

    fetch_state_t state;
    fetch_state_t state_next;
    logic         has_room;  // Buffer below high-water mark

    assign has_room = (count < IBUF_HIGH_WATER);

    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            state <= SEQ_IDLE;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            SEQ_IDLE: begin
                // Redirect cycle only reloads the PC
                if (has_room && !redirect) begin
                    state_next = SEQ_REQUEST;
                end
            end
            SEQ_REQUEST: begin
                // Request still leaves this cycle, its answer belongs to the old stream
                if (redirect) begin
                    state_next = SEQ_DRAIN;
                end else begin
                    state_next = SEQ_WAIT;
                end
            end
            SEQ_WAIT: begin
                if (imem_rvalid) begin
                    state_next = SEQ_IDLE;  // Taken, or dropped on redirect
                end else if (redirect) begin
                    state_next = SEQ_DRAIN;  // Response still on its way
                end
            end
            SEQ_DRAIN: begin
                // Swallow the stale response
                if (imem_rvalid) begin
                    state_next = SEQ_IDLE;
                end
            end
            default: begin
                state_next = SEQ_IDLE;
            end
        endcase
    end

    // Moore request, one cycle per visit to SEQ_REQUEST
    assign imem_req = (state == SEQ_REQUEST);

    // Accept only a response of the live stream
    assign pc_advance = (state == SEQ_WAIT) && imem_rvalid && !redirect;

endmodule

// File: fetch_types_pkg.sv
package fetch_types_pkg;

    // Fetch address, byte granular
    typedef logic [47:0] pc_t;

    // Raw instruction word as returned by memory
    typedef logic [31:0] instr_t;

    // Buffer entry, 80 bits: PC in [79:32], instruction in [31:0]
    typedef logic [$bits(pc_t)+$bits(instr_t)-1:0] ibuf_entry_t;

    // Buffer occupancy, never above 63
    typedef logic [5:0] ibuf_count_t;

    // Fetch sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE    = 2'd0,  // Waiting for room in the buffer
        SEQ_REQUEST = 2'd1,  // Request strobe on the memory port
        SEQ_WAIT    = 2'd2,  // Response pending for the current PC
        SEQ_DRAIN   = 2'd3   // Response pending for a dead stream
    } fetch_state_t;

endpackage

// File: files.f
fetch_types_pkg.sv
fetch_config_pkg.sv
fetch_pc_counter.sv
fetch_sequencer_fsm.sv
instr_buffer.sv
fetch_frontend.sv
fetch_checker.sv
tb_fetch_frontend.sv

// File: instr_buffer.sv
`timescale 1ns/100ps

module instr_buffer (
    input  logic                         clock,
    input  logic                         reset_n,
    input  fetch_types_pkg::ibuf_entry_t data_in,        // {pc, instruction}
    input  logic                         write_en,       // Push strobe
    input  logic                         read_en,        // Pop request from decode
    input  logic                         clear_ibuffer,  // Flush on redirect
    input  logic                         stall,          // Freeze output and read side
    output fetch_types_pkg::ibuf_entry_t data_out,       // Registered head entry
    output logic                         empty,
    output logic                         full,
    output fetch_types_pkg::ibuf_count_t count,
    output logic                         data_valid      // data_out is a fresh entry
);

    import fetch_types_pkg::*;
    import fetch_config_pkg::*;

    ibuf_entry_t           mem [IBUF_DEPTH];  // Entry storage
    logic [IBUF_PTR_W-1:0] write_ptr;
    logic [IBUF_PTR_W-1:0] read_ptr;
    logic                  write_ok;  // Write that really lands
    logic                  read_ok;   // Read that really pops

    assign empty = (count == '0);
    assign full  = (count == IBUF_FULL_COUNT);

    assign write_ok = write_en && !full;
    assign read_ok  = read_en && !empty && !stall;

    always_ff @(posedge clock) begin
        if (write_ok) begin
            mem[write_ptr] <= data_in;
        end
    end

    // Pointers wrap on their own at the 6-bit boundary
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            write_ptr <= '0;
            read_ptr  <= '0;
        end else if (clear_ibuffer) begin
            write_ptr <= '0;
            read_ptr  <= '0;
        end else begin
            if (write_ok) begin
                write_ptr <= write_ptr + 1'b1;
            end
            if (read_ok) begin
                read_ptr <= read_ptr + 1'b1;
            end
        end
    end

    // Output register
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            data_out   <= '0;
            data_valid <= 1'b0;
        end else if (clear_ibuffer) begin
            data_out   <= '0;
            data_valid <= 1'b0;
        end else if (!stall) begin  // Stall holds both
            if (read_ok) begin
                data_out   <= mem[read_ptr];
                data_valid <= 1'b1;
            end else begin
                data_valid <= 1'b0;  // Old data_out kept but marked stale
            end
        end
    end

    // Occupancy, push and pop together cancel out
    always_ff @(posedge clock or negedge reset_n) begin
        if (!reset_n) begin
            count <= '0;
        end else if (clear_ibuffer) begin
            count <= '0;
        end else begin
            case ({write_ok, read_ok})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: tb_fetch_frontend.sv
`timescale 1ns/100ps

module tb_fetch_frontend;

    import fetch_types_pkg::*;

    localparam int clock_period     = 10;
    localparam int first_entries    = 8;
    localparam int stream_entries   = 200;
    localparam int stall_entries    = 100;
    localparam int redirect_entries = 16;
    localparam int late_redirects   = 5;
    localparam int late_entries     = 4;   // Per late redirect
    localparam int drain_entries    = 64;  // Filled to the high-water mark, then drained
    localparam int entry_total      = first_entries + stream_entries + stall_entries
                                      + redirect_entries + late_redirects * late_entries
                                      + drain_entries;
    localparam int margin_cycles    = 1000;

    logic        clock;
    logic        reset_n;
    logic        redirect;
    pc_t         redirect_pc;
    logic        stall;
    logic        read_en;
    logic        imem_rvalid;
    instr_t      imem_rdata;
    logic        imem_req;
    pc_t         imem_addr;
    ibuf_entry_t data_out;
    logic        data_valid;
    logic        empty;
    logic        full;
    ibuf_count_t count;
    int          test_num;
    int          error_count;
    int          entry_count;
    logic [31:0] stim_seed = 32'hd19a;  // Stimulus stream
    logic [31:0] mem_seed = 32'hd19a;   // Memory latency stream
    int          mem_lat;
    int          mem_left = 0;          // Edges until the pending response
    pc_t         mem_addr;

    fetch_frontend UUT (.*);

    fetch_checker u_checker (.*);

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // Word aligned target in a far region
    function automatic pc_t branch_target(input logic [31:0] r);
        return 48'h0000_0010_0000 + {32'h0, r[17:4], 2'b00};
    endfunction

    // Instruction memory contents
    function automatic instr_t mem_word(input pc_t addr);
        instr_t      w;
        int unsigned sh;
        w  = addr[31:0] ^ 32'h5a5a_0000;
        sh = addr[5:2];
        if (sh == 0) return w;
        return (w << sh) | (w >> (32 - sh));  // Rotate left
    endfunction

    task automatic wait_entries(input int n);
        int target;
        target = entry_count + n;
        while (entry_count < target) @(posedge clock);
    endtask

    task automatic redirect_to(input pc_t target);
        redirect    <= 1'b1;
        redirect_pc <= target;
        @(posedge clock);
        redirect    <= 1'b0;  // One-cycle pulse
    endtask

    initial begin
        clock = 1'b0;
        forever #(clock_period / 2) clock = ~clock;
    end

    initial begin
        #((entry_total * 8 + margin_cycles) * clock_period);
        $display("timeout: the tests did not finish in time");
        $display("ERRORS FOUND");
        $finish;
    end

    // Memory, one open request, 1 to 4 cycles of latency
    always @(posedge clock) begin
        if (!reset_n) begin
            imem_rvalid <= 1'b0;
            mem_left    <= 0;
        end else begin
            imem_rvalid <= 1'b0;
            if (imem_req) begin
                mem_seed = lcg_next(mem_seed);
                mem_lat  = 1 + mem_seed[17:16];
                mem_addr <= imem_addr;  // Address at request time
                if (mem_lat == 1) begin
                    imem_rvalid <= 1'b1;
                    imem_rdata  <= mem_word(imem_addr);
                end else begin
                    mem_left <= mem_lat - 1;
                end
            end else if (mem_left != 0) begin
                if (mem_left == 1) begin
                    imem_rvalid <= 1'b1;
                    imem_rdata  <= mem_word(mem_addr);
                end
                mem_left <= mem_left - 1;
            end
        end
    end

    initial begin
        int target;
        reset_n     <= 1'b0;
        redirect    <= 1'b0;
        redirect_pc <= '0;
        stall       <= 1'b0;
        read_en     <= 1'b0;
        imem_rvalid <= 1'b0;
        imem_rdata  <= '0;
        test_num    <= 0;
        repeat (2) @(posedge clock);
        reset_n  <= 1'b1;
        test_num <= 1;
        read_en  <= 1'b1;
        wait_entries(first_entries);
        test_num <= 2;
        wait_entries(stream_entries);
        test_num <= 3;
        target = entry_count + stall_entries;
        while (entry_count < target) begin
            stim_seed = lcg_next(stim_seed);
            case (stim_seed[18:16])
                3'd0: begin  // Stall pulse, 1 to 8 cycles
                    stall <= 1'b1;
                    repeat (1 + stim_seed[22:20]) @(posedge clock);
                    stall <= 1'b0;
                end
                3'd1: begin  // Read gap
                    read_en <= 1'b0;
                    repeat (1 + stim_seed[21:20]) @(posedge clock);
                    read_en <= 1'b1;
                end
                default: ;
            endcase
            @(posedge clock);
        end
        test_num <= 4;
        read_en  <= 1'b0;
        while (count < 6'd10) @(posedge clock);  // Let entries queue up
        stim_seed = lcg_next(stim_seed);
        redirect_to(branch_target(stim_seed));
        read_en <= 1'b1;
        wait_entries(redirect_entries);
        test_num <= 5;
        for (int i = 0; i < late_redirects; i++) begin
            @(posedge clock);
            while (!imem_req) @(posedge clock);
            stim_seed = lcg_next(stim_seed);
            if (stim_seed[16]) @(posedge clock);  // Later in the wait
            redirect_to(branch_target(stim_seed));
            wait_entries(late_entries);
        end
        test_num <= 6;
        read_en  <= 1'b0;
        while (count < 6'd60) @(posedge clock);
        repeat (40) @(posedge clock);  // Count must stay put
        read_en <= 1'b1;
        @(posedge clock);
        while (!empty) @(posedge clock);
        repeat (4) @(posedge clock);
        test_num <= 0;
        repeat (2) @(posedge clock);
        @(negedge clock);  // Error count now includes the last compare
        $display("summary: %0d entries checked, %0d errors", entry_count, error_count);
        if (error_count == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule
